// File: filelist.f
src/cif_dn_pkg.sv
src/cif_dn_src_sel.sv
src/cif_dn_split_fifo.sv
src/cif_dn_chain_out.sv
src/cif_dn_chan_stats.sv
src/cif_dn_top.sv
testbench/tb_cif_dn.sv

// File: Bender.yml
package:
  name: cif_dn

sources:
  - src/cif_dn_pkg.sv
  - src/cif_dn_src_sel.sv
  - src/cif_dn_split_fifo.sv
  - src/cif_dn_chain_out.sv
  - src/cif_dn_chan_stats.sv
  - src/cif_dn_top.sv
  - target: test
    files:
      - testbench/tb_cif_dn.sv

// File: testbench/tb_cif_dn.sv
// downstream channel interface testbench
module tb_cif_dn;
  timeunit 1ns;
  timeprecision 1ps;
  import cif_dn_pkg::*;

  localparam int DATA_W       = 64;
  localparam int CH_NUM       = 32;
  localparam int CHAIN_NUM    = 4;
  localparam int FIFO_DEPTH   = 8;
  localparam int CH_W         = $clog2(CH_NUM);
  localparam int CH_PER_CHAIN = CH_NUM / CHAIN_NUM;
  localparam int TIMEOUT      = 200;

  logic                             user_clk;
  logic                             reset_n;
  logic                             i_d2c_tvalid;
  logic [DATA_W-1:0]                i_d2c_tdata;
  user_t                            i_d2c_tuser;
  logic                             o_d2c_tready;
  logic                             i_dir_tvalid;
  logic [DATA_W-1:0]                i_dir_tdata;
  user_t                            i_dir_tuser;
  logic                             o_dir_tready;
  logic [CHAIN_NUM-1:0]             i_chain_tready;
  logic [CHAIN_NUM-1:0]             o_chain_tvalid;
  logic [CHAIN_NUM-1:0][DATA_W-1:0] o_chain_tdata;
  user_t [CHAIN_NUM-1:0]            o_chain_tuser;
  logic [CH_NUM-1:0]                o_busy;
  logic                             i_count_reset;
  logic [CH_W-1:0]                  i_stat_ch;
  cnt_t                             o_stat_beats;
  cnt_t                             o_stat_pkts;

  // reference model
  logic [DATA_W+USER_W-1:0] model_q [CHAIN_NUM][$];  // {data, user} per chain
  cnt_t                     model_beats [CH_NUM];
  cnt_t                     model_pkts  [CH_NUM];
  logic [CH_NUM-1:0]        busy_exp = '0;
  logic [CHAIN_NUM-1:0]     held_prev = '0;
  logic [DATA_W-1:0]        prev_data [CHAIN_NUM];
  user_t                    prev_user [CHAIN_NUM];
  logic                     d2c_fire = 1'b0;
  logic                     dir_fire = 1'b0;
  logic                     stalled  = 1'b0;
  logic [31:0]              lcg_state;
  int                       errors = 0;
  int                       test_base = 0;
  int                       tests_run = 0;
  int                       tests_failed = 0;

  cif_dn_top #(
    .DATA_W     (DATA_W),
    .CH_NUM     (CH_NUM),
    .CHAIN_NUM  (CHAIN_NUM),
    .FIFO_DEPTH (FIFO_DEPTH)
  ) i_cif_dn_top (
    .user_clk       (user_clk),
    .reset_n        (reset_n),
    .i_d2c_tvalid   (i_d2c_tvalid),
    .i_d2c_tdata    (i_d2c_tdata),
    .i_d2c_tuser    (i_d2c_tuser),
    .o_d2c_tready   (o_d2c_tready),
    .i_dir_tvalid   (i_dir_tvalid),
    .i_dir_tdata    (i_dir_tdata),
    .i_dir_tuser    (i_dir_tuser),
    .o_dir_tready   (o_dir_tready),
    .i_chain_tready (i_chain_tready),
    .o_chain_tvalid (o_chain_tvalid),
    .o_chain_tdata  (o_chain_tdata),
    .o_chain_tuser  (o_chain_tuser),
    .o_busy         (o_busy),
    .i_count_reset  (i_count_reset),
    .i_stat_ch      (i_stat_ch),
    .o_stat_beats   (o_stat_beats),
    .o_stat_pkts    (o_stat_pkts)
  );

  initial begin
    user_clk = 1'b0;
    forever #10 user_clk = ~user_clk;
  end

  //////////////////////////////
  // helpers
  //////////////////////////////
  task automatic compare(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, exp);
    end
  endtask

  task automatic report_failure(input string msg);
    errors++;
    $display("%s", msg);
  endtask

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // only_chain < 0 picks any channel
  function automatic user_t make_user(input logic [31:0] r, input int only_chain);
    user_t           u;
    logic [CH_W-1:0] ch;
    if (only_chain < 0) begin
      ch = r[CH_W+7:8];
    end else begin
      ch = CH_W'(only_chain * CH_PER_CHAIN + int'(r[10:8]) % CH_PER_CHAIN);
    end
    u = '0;
    u[SOP_BIT-1:0]     = r[SOP_BIT-1:0];
    u[SOP_BIT]         = r[16];
    u[CH_LSB +: CH_W]  = ch;
    return u;
  endfunction

  function automatic int pending();
    int n;
    n = 0;
    for (int c = 0; c < CHAIN_NUM; c++) begin
      n += model_q[c].size();
    end
    return n;
  endfunction

  task automatic drive_traffic(input int cycles, input int only_chain,
                               input logic [CHAIN_NUM-1:0] hold_low,
                               input int vthresh, input bit slow_out);
    logic [31:0] r;
    for (int i = 0; i < cycles; i++) begin
      @(posedge user_clk);
      r = next_rand();
      if (!i_d2c_tvalid || d2c_fire) begin  // hold a beat until taken
        i_d2c_tvalid <= (r[3:0] < vthresh);
        i_d2c_tdata  <= {next_rand(), next_rand()};
        i_d2c_tuser  <= make_user(next_rand(), only_chain);
      end
      if (!i_dir_tvalid || dir_fire) begin
        i_dir_tvalid <= (r[7:4] < vthresh);
        i_dir_tdata  <= {next_rand(), next_rand()};
        i_dir_tuser  <= make_user(next_rand(), only_chain);
      end
      i_chain_tready <= (slow_out ? (r[11:8] & r[15:12]) : (r[11:8] | r[15:12])) & ~hold_low;
    end
  endtask

  // stop sources, open all chains, then wait for queues and busy to clear
  task automatic drain();
    int n;
    @(posedge user_clk);
    i_d2c_tvalid   <= 1'b0;
    i_dir_tvalid   <= 1'b0;
    i_chain_tready <= '1;
    n = 0;
    while (pending() != 0 && n < TIMEOUT) begin
      @(posedge user_clk);
      n++;
    end
    if (pending() != 0) begin
      report_failure($sformatf("timeout: %0d queued beats never reached a chain", pending()));
    end
    n = 0;
    @(negedge user_clk);
    while (o_busy != '0 && n < TIMEOUT) begin
      @(negedge user_clk);
      n++;
    end
    if (o_busy != '0) begin
      report_failure("timeout: busy vector did not return to zero after drain");
    end
  endtask

  task automatic check_stats(input bit expect_zero);
    for (int ch = 0; ch < CH_NUM; ch++) begin
      @(posedge user_clk);
      i_stat_ch <= CH_W'(ch);
      @(negedge user_clk);
      compare($sformatf("o_stat_beats[%0d]", ch), o_stat_beats,
              expect_zero ? '0 : model_beats[ch]);
      compare($sformatf("o_stat_pkts[%0d]", ch), o_stat_pkts,
              expect_zero ? '0 : model_pkts[ch]);
    end
  endtask

  task automatic end_test(input string name);
    tests_run++;
    if (errors != test_base) begin
      tests_failed++;
    end
    $display("test %-12s %s (%0d errors)", name, (errors == test_base) ? "ok" : "failing",
             errors - test_base);
    test_base = errors;
  endtask

  //////////////////////////////
  // monitor and model
  //////////////////////////////
  always @(negedge user_clk) begin
    logic [CH_NUM-1:0]        mask;
    logic [DATA_W+USER_W-1:0] front;
    logic [CH_W-1:0]          ch;
    user_t                    acc_user;
    if (reset_n) begin
      compare("o_busy", o_busy, busy_exp);  // reflects state one edge back
      mask = '0;
      for (int c = 0; c < CHAIN_NUM; c++) begin
        for (int k = 0; k < model_q[c].size(); k++) begin
          mask[model_q[c][k][CH_LSB +: CH_W]] = 1'b1;
        end
      end
      busy_exp = mask;
      if (i_d2c_tvalid) begin
        compare("o_dir_tready", o_dir_tready, 1'b0);
      end
      if (pending() <= 1) begin  // fifo holds at most what the model holds
        compare("o_d2c_tready", o_d2c_tready, 1'b1);
        compare("o_dir_tready", o_dir_tready, !i_d2c_tvalid);
      end
      d2c_fire = i_d2c_tvalid & o_d2c_tready;
      dir_fire = i_dir_tvalid & o_dir_tready;
      acc_user = d2c_fire ? i_d2c_tuser : i_dir_tuser;
      ch       = acc_user[CH_LSB +: CH_W];
      if (d2c_fire || dir_fire) begin
        model_q[int'(ch) / CH_PER_CHAIN].push_back(d2c_fire ? {i_d2c_tdata, i_d2c_tuser}
                                                             : {i_dir_tdata, i_dir_tuser});
      end
      if (i_count_reset) begin
        for (int i = 0; i < CH_NUM; i++) begin
          model_beats[i] = '0;
          model_pkts[i]  = '0;
        end
      end else if (d2c_fire || dir_fire) begin
        model_beats[ch]++;
        if (acc_user[SOP_BIT]) begin
          model_pkts[ch]++;
        end
      end
      for (int c = 0; c < CHAIN_NUM; c++) begin
        if (held_prev[c]) begin  // back-pressured last cycle
          compare($sformatf("o_chain_tvalid[%0d]", c), o_chain_tvalid[c], 1'b1);
          compare($sformatf("o_chain_tdata[%0d]", c), o_chain_tdata[c], prev_data[c]);
          compare($sformatf("o_chain_tuser[%0d]", c), o_chain_tuser[c], prev_user[c]);
        end
        if (o_chain_tvalid[c] && i_chain_tready[c]) begin
          if (model_q[c].size() == 0) begin
            report_failure($sformatf("chain %0d delivered a beat that was never accepted", c));
          end else begin
            front = model_q[c].pop_front();
            compare($sformatf("o_chain_tdata[%0d]", c), o_chain_tdata[c], front[USER_W +: DATA_W]);
            compare($sformatf("o_chain_tuser[%0d]", c), o_chain_tuser[c], front[USER_W-1:0]);
          end
        end
        held_prev[c] = o_chain_tvalid[c] & ~i_chain_tready[c];
        prev_data[c] = o_chain_tdata[c];
        prev_user[c] = o_chain_tuser[c];
      end
      stalled = !o_d2c_tready && !o_dir_tready;
    end
  end

  //////////////////////////////
  // test sequence
  //////////////////////////////
  initial begin
    lcg_state = 32'h7aad_a586;
    for (int i = 0; i < CH_NUM; i++) begin
      model_beats[i] = '0;
      model_pkts[i]  = '0;
    end
    reset_n        <= 1'b0;
    i_d2c_tvalid   <= 1'b0;
    i_d2c_tdata    <= '0;
    i_d2c_tuser    <= '0;
    i_dir_tvalid   <= 1'b0;
    i_dir_tdata    <= '0;
    i_dir_tuser    <= '0;
    i_chain_tready <= '0;
    i_count_reset  <= 1'b0;
    i_stat_ch      <= '0;
    repeat (3) @(posedge user_clk);
    reset_n <= 1'b1;

    @(negedge user_clk);
    compare("o_chain_tvalid", o_chain_tvalid, '0);
    compare("o_busy", o_busy, '0);
    check_stats(1'b1);
    end_test("reset");

    drive_traffic(400, -1, '0, 10, 1'b0);
    drain();
    check_stats(1'b0);
    end_test("ordering");

    drive_traffic(100, -1, '0, 16, 1'b0);  // both sources always valid
    drain();
    end_test("priority");

    drive_traffic(4, 0, '0, 16, 1'b0);
    for (int i = 0; i < 40 && !stalled; i++) begin
      drive_traffic(1, 0, 4'b0001, 16, 1'b0);
    end
    if (!stalled) begin
      report_failure("input readies stayed high while chain 0 was stalled");
    end
    drive_traffic(10, 0, 4'b0001, 16, 1'b0);
    drain();
    check_stats(1'b0);
    end_test("backpressure");

    drive_traffic(200, -1, '0, 6, 1'b1);
    drain();
    end_test("busy");

    check_stats(1'b0);
    @(posedge user_clk);
    i_count_reset <= 1'b1;
    @(posedge user_clk);
    i_count_reset <= 1'b0;
    check_stats(1'b1);
    end_test("statistics");

    $display("tests run %0d, failing %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

// File: src/cif_dn_top.sv
// downstream channel interface top
module cif_dn_top #(
  parameter int DATA_W     = 64,
  parameter int CH_NUM     = 32,
  parameter int CHAIN_NUM  = 4,
  parameter int FIFO_DEPTH = 8
) (
  input  logic                               user_clk,
  input  logic                               reset_n,
  // dma receive stream
  input  logic                               i_d2c_tvalid,
  input  logic [DATA_W-1:0]                  i_d2c_tdata,
  input  cif_dn_pkg::user_t                  i_d2c_tuser,
  output logic                               o_d2c_tready,
  // direct bridge stream
  input  logic                               i_dir_tvalid,
  input  logic [DATA_W-1:0]                  i_dir_tdata,
  input  cif_dn_pkg::user_t                  i_dir_tuser,
  output logic                               o_dir_tready,
  // chain outputs
  input  logic [CHAIN_NUM-1:0]               i_chain_tready,
  output logic [CHAIN_NUM-1:0]               o_chain_tvalid,
  output logic [CHAIN_NUM-1:0][DATA_W-1:0]   o_chain_tdata,
  output cif_dn_pkg::user_t [CHAIN_NUM-1:0]  o_chain_tuser,
  output logic [CH_NUM-1:0]                  o_busy,
  // statistics
  input  logic                               i_count_reset,
  input  logic [$clog2(CH_NUM)-1:0]          i_stat_ch,
  output cif_dn_pkg::cnt_t                   o_stat_beats,
  output cif_dn_pkg::cnt_t                   o_stat_pkts
);
  import cif_dn_pkg::*;

  logic                 fifo_ready;
  logic                 wr_valid;
  logic [DATA_W-1:0]    wr_data;
  user_t                wr_user;
  logic [CHAIN_NUM-1:0] pop;
  logic [DATA_W-1:0]    pop_data;
  user_t                pop_user;
  logic [CH_NUM-1:0]    ch_held;

  cif_dn_src_sel #(
    .DATA_W (DATA_W)
  ) i_src_sel (
    .i_d2c_tvalid (i_d2c_tvalid),
    .i_d2c_tdata  (i_d2c_tdata),
    .i_d2c_tuser  (i_d2c_tuser),
    .o_d2c_tready (o_d2c_tready),
    .i_dir_tvalid (i_dir_tvalid),
    .i_dir_tdata  (i_dir_tdata),
    .i_dir_tuser  (i_dir_tuser),
    .o_dir_tready (o_dir_tready),
    .i_fifo_ready (fifo_ready),
    .o_wr_valid   (wr_valid),
    .o_wr_data    (wr_data),
    .o_wr_user    (wr_user)
  );

  cif_dn_split_fifo #(
    .DATA_W     (DATA_W),
    .CH_NUM     (CH_NUM),
    .CHAIN_NUM  (CHAIN_NUM),
    .FIFO_DEPTH (FIFO_DEPTH)
  ) i_split_fifo (
    .user_clk      (user_clk),
    .reset_n       (reset_n),
    .i_wr_valid    (wr_valid),
    .i_wr_data     (wr_data),
    .i_wr_user     (wr_user),
    .i_chain_ready (i_chain_tready),  // downstream ready gates the pop
    .o_fifo_ready  (fifo_ready),
    .o_pop         (pop),
    .o_pop_data    (pop_data),
    .o_pop_user    (pop_user),
    .o_ch_held     (ch_held)
  );

  cif_dn_chain_out #(
    .DATA_W    (DATA_W),
    .CH_NUM    (CH_NUM),
    .CHAIN_NUM (CHAIN_NUM)
  ) i_chain_out (
    .user_clk       (user_clk),
    .reset_n        (reset_n),
    .i_pop          (pop),
    .i_pop_data     (pop_data),
    .i_pop_user     (pop_user),
    .i_ch_held      (ch_held),
    .i_chain_tready (i_chain_tready),
    .o_chain_tvalid (o_chain_tvalid),
    .o_chain_tdata  (o_chain_tdata),
    .o_chain_tuser  (o_chain_tuser),
    .o_busy         (o_busy)
  );

  // accepted beats are exactly the fifo writes
  cif_dn_chan_stats #(
    .CH_NUM (CH_NUM)
  ) i_chan_stats (
    .user_clk      (user_clk),
    .reset_n       (reset_n),
    .i_acc_valid   (wr_valid),
    .i_acc_user    (wr_user),
    .i_count_reset (i_count_reset),
    .i_stat_ch     (i_stat_ch),
    .o_stat_beats  (o_stat_beats),
    .o_stat_pkts   (o_stat_pkts)
  );

endmodule

// File: src/cif_dn_chan_stats.sv
// per-channel beat and packet counters
module cif_dn_chan_stats #(
  parameter int CH_NUM = 32
) (
  input  logic                      user_clk,
  input  logic                      reset_n,
  input  logic                      i_acc_valid,
  input  cif_dn_pkg::user_t         i_acc_user,
  input  logic                      i_count_reset,
  input  logic [$clog2(CH_NUM)-1:0] i_stat_ch,
  output cif_dn_pkg::cnt_t          o_stat_beats,
  output cif_dn_pkg::cnt_t          o_stat_pkts
);
  import cif_dn_pkg::*;

  localparam int CH_W = $clog2(CH_NUM);

  cnt_t            beat_cnt [CH_NUM];
  cnt_t            pkt_cnt  [CH_NUM];
  logic [CH_W-1:0] acc_ch;

  assign acc_ch = CH_W'(user_ch(i_acc_user));

  always_ff @(posedge user_clk or negedge reset_n) begin
    if (!reset_n) begin
      for (int i = 0; i < CH_NUM; i++) begin
        beat_cnt[i] <= '0;
        pkt_cnt[i]  <= '0;
      end
    end else if (i_count_reset) begin  // level clear, beats dropped meanwhile
      for (int i = 0; i < CH_NUM; i++) begin
        beat_cnt[i] <= '0;
        pkt_cnt[i]  <= '0;
      end
    end else if (i_acc_valid) begin
      beat_cnt[acc_ch] <= beat_cnt[acc_ch] + 1'b1;
      if (is_sop(i_acc_user)) begin
        pkt_cnt[acc_ch] <= pkt_cnt[acc_ch] + 1'b1;
      end
    end
  end

  // indexed read
  assign o_stat_beats = beat_cnt[i_stat_ch];
  assign o_stat_pkts  = pkt_cnt[i_stat_ch];

endmodule

// File: src/cif_dn_chain_out.sv
// chain output stage
module cif_dn_chain_out #(
  parameter int DATA_W    = 64,
  parameter int CH_NUM    = 32,
  parameter int CHAIN_NUM = 4
) (
  input  logic                                user_clk,
  input  logic                                reset_n,
  input  logic [CHAIN_NUM-1:0]                i_pop,
  input  logic [DATA_W-1:0]                   i_pop_data,
  input  cif_dn_pkg::user_t                   i_pop_user,
  input  logic [CH_NUM-1:0]                   i_ch_held,
  input  logic [CHAIN_NUM-1:0]                i_chain_tready,
  output logic [CHAIN_NUM-1:0]                o_chain_tvalid,
  output logic [CHAIN_NUM-1:0][DATA_W-1:0]    o_chain_tdata,
  output cif_dn_pkg::user_t [CHAIN_NUM-1:0]   o_chain_tuser,
  output logic [CH_NUM-1:0]                   o_busy
);
  import cif_dn_pkg::*;

  localparam int CH_W = $clog2(CH_NUM);

  logic [CH_NUM-1:0] out_held;

  //////////////////////////////
  // per-chain output registers
  //////////////////////////////
  always_ff @(posedge user_clk or negedge reset_n) begin
    if (!reset_n) begin
      o_chain_tvalid <= '0;
    end else begin
      for (int c = 0; c < CHAIN_NUM; c++) begin
        if (i_chain_tready[c]) begin
          o_chain_tvalid[c] <= i_pop[c];  // drops valid when nothing popped
        end
      end
    end
  end

  always_ff @(posedge user_clk) begin
    for (int c = 0; c < CHAIN_NUM; c++) begin
      if (i_chain_tready[c] && i_pop[c]) begin
        o_chain_tdata[c] <= i_pop_data;
        o_chain_tuser[c] <= i_pop_user;
      end
    end
  end

  //////////////////////////////
  // channel busy
  //////////////////////////////
  always_comb begin
    out_held = '0;
    for (int c = 0; c < CHAIN_NUM; c++) begin
      if (o_chain_tvalid[c]) begin
        out_held[CH_W'(user_ch(o_chain_tuser[c]))] = 1'b1;
      end
    end
  end

  always_ff @(posedge user_clk or negedge reset_n) begin
    if (!reset_n) begin
      o_busy <= '0;
    end else begin
      o_busy <= i_ch_held | out_held;
    end
  end

  // a pop into a stalled register would be lost
  for (genvar c = 0; c < CHAIN_NUM; c++) begin : g_pop_chk
    a_pop_needs_ready: assert property (@(posedge user_clk) disable iff (!reset_n)
      i_pop[c] |-> i_chain_tready[c])
      else $error("chain %0d popped while its output was stalled", c);
  end

endmodule

// File: src/cif_dn_split_fifo.sv
// split fifo toward chains
module cif_dn_split_fifo #(
  parameter int DATA_W     = 64,
  parameter int CH_NUM     = 32,
  parameter int CHAIN_NUM  = 4,
  parameter int FIFO_DEPTH = 8
) (
  input  logic                  user_clk,
  input  logic                  reset_n,
  input  logic                  i_wr_valid,
  input  logic [DATA_W-1:0]     i_wr_data,
  input  cif_dn_pkg::user_t     i_wr_user,
  input  logic [CHAIN_NUM-1:0]  i_chain_ready,
  output logic                  o_fifo_ready,
  output logic [CHAIN_NUM-1:0]  o_pop,
  output logic [DATA_W-1:0]     o_pop_data,
  output cif_dn_pkg::user_t     o_pop_user,
  output logic [CH_NUM-1:0]     o_ch_held
);
  import cif_dn_pkg::*;

  localparam int CH_W         = $clog2(CH_NUM);
  localparam int CHAIN_W      = $clog2(CHAIN_NUM);
  localparam int CH_PER_CHAIN = CH_NUM / CHAIN_NUM;
  localparam int PTR_W        = $clog2(FIFO_DEPTH);
  localparam int OCC_W        = $clog2(FIFO_DEPTH + 1);

  logic [DATA_W-1:0]  mem_data [FIFO_DEPTH];
  user_t              mem_user [FIFO_DEPTH];
  logic [PTR_W-1:0]   wr_ptr;
  logic [PTR_W-1:0]   rd_ptr;
  logic [OCC_W-1:0]   count;
  logic [CH_W-1:0]    head_ch;
  logic [CHAIN_W-1:0] head_chain;
  logic               pop_en;

  //////////////////////////////
  // head decode
  //////////////////////////////
  assign head_ch    = CH_W'(user_ch(mem_user[rd_ptr]));
  assign head_chain = CHAIN_W'(head_ch / CH_PER_CHAIN);
  assign pop_en     = (count != '0) & i_chain_ready[head_chain];

  always_comb begin
    o_pop             = '0;
    o_pop[head_chain] = pop_en;
  end

  assign o_pop_data   = mem_data[rd_ptr];
  assign o_pop_user   = mem_user[rd_ptr];
  assign o_fifo_ready = (count <= OCC_W'(1));  // keeps room for in-flight beats

  //////////////////////////////
  // storage and pointers
  //////////////////////////////
  always_ff @(posedge user_clk) begin
    if (i_wr_valid) begin
      mem_data[wr_ptr] <= i_wr_data;
      mem_user[wr_ptr] <= i_wr_user;
    end
  end

  always_ff @(posedge user_clk or negedge reset_n) begin
    if (!reset_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (i_wr_valid) begin
        wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop_en) begin
        rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      count <= count + OCC_W'(i_wr_valid) - OCC_W'(pop_en);
    end
  end

  // channels with a beat still queued
  always_comb begin
    int idx;
    o_ch_held = '0;
    for (int j = 0; j < FIFO_DEPTH; j++) begin
      idx = (int'(rd_ptr) + j) % FIFO_DEPTH;
      if (j < int'(count)) begin
        o_ch_held[CH_W'(user_ch(mem_user[idx]))] = 1'b1;
      end
    end
  end

  a_count_bound: assert property (@(posedge user_clk) disable iff (!reset_n)
    count <= OCC_W'(FIFO_DEPTH))
    else $error("fifo count above depth");

endmodule

// File: src/cif_dn_src_sel.sv
// input source select
module cif_dn_src_sel #(
  parameter int DATA_W = 64
) (
  // dma receive stream
  input  logic              i_d2c_tvalid,
  input  logic [DATA_W-1:0] i_d2c_tdata,
  input  cif_dn_pkg::user_t i_d2c_tuser,
  output logic              o_d2c_tready,
  // direct bridge stream
  input  logic              i_dir_tvalid,
  input  logic [DATA_W-1:0] i_dir_tdata,
  input  cif_dn_pkg::user_t i_dir_tuser,
  output logic              o_dir_tready,
  // fifo write side
  input  logic              i_fifo_ready,
  output logic              o_wr_valid,
  output logic [DATA_W-1:0] o_wr_data,
  output cif_dn_pkg::user_t o_wr_user
);

  // dma stream always wins
  assign o_d2c_tready = i_fifo_ready;
  assign o_dir_tready = i_fifo_ready & ~i_d2c_tvalid;  // only in a dma idle cycle

  assign o_wr_valid = (i_d2c_tvalid & o_d2c_tready) | (i_dir_tvalid & o_dir_tready);
  assign o_wr_data  = i_d2c_tvalid ? i_d2c_tdata : i_dir_tdata;
  assign o_wr_user  = i_d2c_tvalid ? i_d2c_tuser : i_dir_tuser;

endmodule

// File: src/cif_dn_pkg.sv
// downstream channel interface package
package cif_dn_pkg;

  //////////////////////////////
  // user field layout
  //////////////////////////////
  localparam int USER_W  = 16;
  localparam int SOP_BIT = 7;   // start of packet
  localparam int CH_LSB  = 8;   // channel number starts here

  // statistics counters wrap
  localparam int CNT_W = 16;

  typedef logic [USER_W-1:0] user_t;
  typedef logic [CNT_W-1:0]  cnt_t;

  // full channel field, callers truncate to their channel width
  function automatic logic [USER_W-CH_LSB-1:0] user_ch(input user_t user);
    return user[USER_W-1:CH_LSB];
  endfunction

  function automatic logic is_sop(input user_t user);
    return user[SOP_BIT];
  endfunction

endpackage
